// ==== verilog.f ====
openadc_hw_pkg.sv
openadc_reg_pkg.sv
multibyte_reg.sv
trigger_unit.sv
reg_openadc.sv
openadc_top.sv
tb_openadc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module tb_openadc --Mdir obj_dir -o tb_openadc -f verilog.f
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_openadc 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1

// ==== tb_openadc.sv ====
`timescale 1ns/1ns

module tb_openadc
   import openadc_hw_pkg::*;
   import openadc_reg_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 4000;   // tests need well under half of this

   logic                 clk_usb = 1'b0;
   logic                 adc_sampleclk_i = 1'b0;
   logic                 reset_i, reg_read_i, reg_write_i, trig_in_i;
   logic                 clkgen_locked_i, dcm_locked_i;
   logic [7:0]           reg_address_i, reg_wdata_i, status_i;
   logic [BYTECNT_W-1:0] reg_bytecnt_i;
   logic                 reset_o, hilow_o, phase_ld_o, dcm_reset_o, capture_go_o;
   logic [7:0]           reg_rdata_o, gain_o;
   phase_t               phase_o;
   samples_t             maxsamples_o;
   presamples_t          presamples_o;
   logic [12:0]          downsample_o;
   logic [2:0]           adc_clk_src_o;

   logic [7:0]  m_gain, m_settings, m_echo;   // register map model
   logic [31:0] m_samples, m_presamples, m_offset, m_decimate, m_phase, m_advclock;
   logic [31:0] m_trig_len;
   logic        m_soft = 1'b0;
   logic        exp_valid = 1'b0;
   logic        chk_valid = 1'b0;
   logic        idle_check_on = 1'b0;
   logic [7:0]  exp_byte, chk_byte, chk_addr;
   int          chk_lane;
   int          err_count = 0;
   int          check_count = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          ld_count = 0;
   int          cycle_count;
   int          seed;
   logic [7:0]  addr_list [13] = '{GAIN_ADDR, SETTINGS_ADDR, STATUS_ADDR, ECHO_ADDR,
      VERSION_ADDR, PHASE_ADDR, DECIMATE_ADDR, SAMPLES_ADDR, PRESAMPLES_ADDR,
      TRIGGER_DUR_ADDR, OFFSET_ADDR, ADVCLOCK_ADDR, SYSTEMCLK_ADDR};
   logic [7:0]  wr_list [6] = '{SAMPLES_ADDR, PRESAMPLES_ADDR, OFFSET_ADDR,
      DECIMATE_ADDR, PHASE_ADDR, ADVCLOCK_ADDR};

   openadc_top i_openadc_top (.*);

   always #10 clk_usb = ~clk_usb;

   // sample clock rises 5 ns before each clk_usb edge
   always begin
      #5 adc_sampleclk_i = 1'b1;
      #10 adc_sampleclk_i = 1'b0;
      #5;
   end

   function automatic logic [7:0] lane_of(input logic [63:0] word, input int lane);
      if (lane > 7) begin
         return 8'h00;
      end
      return word[lane*8 +: 8];
   endfunction

   // byte write into a register that is width bits wide
   function automatic logic [31:0] put_lane(input logic [31:0] word, input int lane,
                                            input logic [7:0] data, input int width);
      logic [31:0] w;
      w = word;
      if (lane < (width + 7) / 8) begin
         w[lane*8 +: 8] = data;
      end
      return w & 32'((64'h1 << width) - 64'h1);
   endfunction

   function automatic logic [7:0] expected_byte(input logic [7:0] addr, input int lane);
      logic [31:0] adv;
      adv = m_advclock;
      adv[5] = clkgen_locked_i;   // live lock bits replace stored ones
      adv[6] = dcm_locked_i;
      adv[7] = 1'b1;
      adv[25] = 1'b0;
      case (addr)
         GAIN_ADDR:        return m_gain;   // single-byte regs ignore the lane
         SETTINGS_ADDR:    return m_settings;
         STATUS_ADDR:      return status_i;
         ECHO_ADDR:        return m_echo;
         VERSION_ADDR:     return lane_of({48'h0, HW_TYPE, HW_VER, 4'h0, REGISTER_VERSION}, lane);
         PHASE_ADDR:       return lane_of({32'h0, m_phase}, lane);
         DECIMATE_ADDR:    return lane_of({32'h0, m_decimate}, lane);
         SAMPLES_ADDR:     return lane_of({32'h0, m_samples}, lane);
         PRESAMPLES_ADDR:  return lane_of({32'h0, m_presamples}, lane);
         TRIGGER_DUR_ADDR: return lane_of({32'h0, m_trig_len}, lane);
         OFFSET_ADDR:      return lane_of({32'h0, m_offset}, lane);
         ADVCLOCK_ADDR:    return lane_of({32'h0, adv}, lane);
         SYSTEMCLK_ADDR:   return lane_of({32'h0, SYSTEM_CLK_HZ}, lane);
         default:          return 8'h00;
      endcase
   endfunction

   task automatic model_defaults();
      m_gain = 8'h00;
      m_settings = 8'h00;
      m_echo = 8'h00;
      m_samples = SAMPLES_DEFAULT;
      m_presamples = '0;
      m_offset = '0;
      m_decimate = '0;
      m_phase = '0;
      m_advclock = ADVCLOCK_DEFAULT;
   endtask

   task automatic model_write(input logic [7:0] addr, input int lane, input logic [7:0] data);
      if (addr == RESET_ADDR) begin
         m_soft = data[0];
      end else if (!m_soft) begin   // writes are lost while soft reset holds
         case (addr)
            GAIN_ADDR:       m_gain = data;
            SETTINGS_ADDR:   m_settings = data;
            ECHO_ADDR:       m_echo = data;
            SAMPLES_ADDR:    m_samples = put_lane(m_samples, lane, data, 32);
            PRESAMPLES_ADDR: m_presamples = put_lane(m_presamples, lane, data, 15);
            OFFSET_ADDR:     m_offset = put_lane(m_offset, lane, data, 32);
            DECIMATE_ADDR:   m_decimate = put_lane(m_decimate, lane, data, 16);
            PHASE_ADDR:      m_phase = put_lane(m_phase, lane, data, 16);
            ADVCLOCK_ADDR:   m_advclock = put_lane(m_advclock, lane, data, 32);
            default: ;
         endcase
      end
      if (m_soft) begin
         model_defaults();
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input int lane, input logic [7:0] data);
      @(posedge clk_usb);
      #2;
      reg_write_i = 1'b1;
      reg_address_i = addr;
      reg_bytecnt_i = BYTECNT_W'(lane);
      reg_wdata_i = data;
      @(posedge clk_usb);
      #2;
      reg_write_i = 1'b0;
      model_write(addr, lane, data);
   endtask

   task automatic bus_read(input logic [7:0] addr, input int lane);
      @(posedge clk_usb);
      #2;
      reg_read_i = 1'b1;
      reg_address_i = addr;
      reg_bytecnt_i = BYTECNT_W'(lane);
      exp_byte = expected_byte(addr, lane);
      exp_valid = 1'b1;
      @(posedge clk_usb);
      #2;
      reg_read_i = 1'b0;
      exp_valid = 1'b0;
   endtask

   // settings outputs of the top level against the register model
   task automatic check_outputs();
      if (gain_o !== m_gain || hilow_o !== m_settings[SET_HILOW] ||
          maxsamples_o !== m_samples || presamples_o !== m_presamples[14:0] ||
          downsample_o !== m_decimate[12:0] || adc_clk_src_o !== m_advclock[2:0] ||
          dcm_reset_o !== m_advclock[4]) begin
         $display("error at %0t ns: settings outputs differ from the register model", $time);
         err_count++;
      end
   endtask

   // arm, fire the trigger, and time capture_go_o in sample edges
   task automatic trigger_trial(input int offs, input int hold, input logic use_now);
      int go_count;
      int go_edge;
      go_count = 0;
      go_edge = -1;
      for (int l = 0; l < 4; l++) begin
         bus_write(OFFSET_ADDR, l, 8'(offs >> (8 * l)));
      end
      bus_write(SETTINGS_ADDR, 0, 8'(1 << SET_TRIG_MODE));   // arm low first
      repeat (8) @(posedge adc_sampleclk_i);
      bus_write(SETTINGS_ADDR, 0, 8'((1 << SET_TRIG_MODE) | (1 << SET_ARM)));
      repeat (8) @(posedge adc_sampleclk_i);
      if (use_now) begin
         bus_write(SETTINGS_ADDR, 0,
                   8'((1 << SET_TRIG_MODE) | (1 << SET_ARM) | (1 << SET_TRIG_NOW)));
      end else begin
         #2;
         trig_in_i = 1'b1;
      end
      for (int k = 1; k <= offs + hold + 6; k++) begin   // edge k = 1 is the trigger edge
         @(posedge adc_sampleclk_i);
         #1;
         if (capture_go_o) begin
            go_count++;
            go_edge = k - 1;
         end
         #1;
         if (!use_now && k == hold) begin
            trig_in_i = 1'b0;
         end
      end
      if (go_count != 1 || go_edge != offs + 1) begin
         $display("error at %0t ns: %0d capture pulses, last %0d edges after trigger, want %0d",
                  $time, go_count, go_edge, offs + 1);
         err_count++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
      end
   endtask

   // reg_rdata_o holds the read byte one edge after the strobe, zero otherwise
   always begin
      @(posedge clk_usb);
      chk_valid = exp_valid;
      chk_byte = exp_byte;
      chk_addr = reg_address_i;
      chk_lane = int'(reg_bytecnt_i);
      @(negedge clk_usb);
      if (chk_valid) begin
         check_count++;
         if (reg_rdata_o !== chk_byte) begin
            $display("error at %0t ns: read addr %0d lane %0d got %h expected %h",
                     $time, chk_addr, chk_lane, reg_rdata_o, chk_byte);
            err_count++;
         end
      end else if (idle_check_on && reg_rdata_o !== 8'h00) begin
         $display("error at %0t ns: read data %h outside a read cycle", $time, reg_rdata_o);
         err_count++;
      end
   end

   always @(negedge clk_usb) begin
      if (phase_ld_o) begin
         ld_count++;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk_usb);
         cycle_count++;
      end
      $display("timeout: tests still running after %0d clk_usb cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int errs;
      int pick;
      int offs;
      int hold;
      seed = 32'h4f5b9d1b;
      reset_i = 1'b1;
      reg_read_i = 1'b0;
      reg_write_i = 1'b0;
      reg_address_i = 8'h00;
      reg_bytecnt_i = '0;
      reg_wdata_i = 8'h00;
      trig_in_i = 1'b0;
      clkgen_locked_i = 1'b1;
      dcm_locked_i = 1'b0;
      status_i = 8'($random(seed));
      model_defaults();
      m_trig_len = '0;
      repeat (10) @(posedge clk_usb);
      #2;
      reset_i = 1'b0;
      idle_check_on = 1'b1;

      errs = err_count;
      foreach (addr_list[i]) begin
         for (int lane = 0; lane < 8; lane++) begin
            bus_read(addr_list[i], lane);
         end
      end
      check_outputs();
      finish_test("reset defaults", errs);

      errs = err_count;
      for (int n = 0; n < 40; n++) begin
         pick = $unsigned($random(seed)) % 6;
         bus_write(wr_list[pick], $unsigned($random(seed)) % 6, 8'($random(seed)));
         for (int lane = 0; lane < 4; lane++) begin
            bus_read(wr_list[pick], lane);
         end
      end
      bus_write(GAIN_ADDR, 0, 8'($random(seed)));
      bus_write(SETTINGS_ADDR, 0, 8'(1 << SET_HILOW));
      check_outputs();
      bus_read(8'd3, 0);   // unmapped addresses
      bus_read(8'd60, 0);
      bus_read(8'd200, 1);
      finish_test("multi-byte writes", errs);

      errs = err_count;
      ld_count = 0;
      bus_write(PHASE_ADDR, 0, 8'($random(seed)));
      repeat (3) @(posedge clk_usb);
      if (ld_count != 0) begin
         $display("error at %0t ns: phase load pulse after a lane 0 write", $time);
         err_count++;
      end
      bus_write(PHASE_ADDR, 1, 8'($random(seed)));
      if (phase_ld_o !== 1'b1 || phase_o !== m_phase[15:0]) begin
         $display("error at %0t ns: phase %h load %b, expected %h with load 1",
                  $time, phase_o, phase_ld_o, m_phase[15:0]);
         err_count++;
      end
      repeat (3) @(posedge clk_usb);
      if (ld_count != 1) begin
         $display("error at %0t ns: %0d phase load pulses, expected 1", $time, ld_count);
         err_count++;
      end
      finish_test("phase load", errs);

      errs = err_count;
      bus_write(ECHO_ADDR, 0, 8'h80 | 8'($random(seed)));
      bus_write(GAIN_ADDR, 0, 8'($random(seed)));
      bus_read(ECHO_ADDR, 0);
      bus_write(RESET_ADDR, 0, 8'h01);
      if (reset_o !== 1'b1) begin
         $display("error at %0t ns: reset_o %b after soft reset write", $time, reset_o);
         err_count++;
      end
      bus_read(ECHO_ADDR, 0);
      bus_read(GAIN_ADDR, 0);
      bus_write(ECHO_ADDR, 0, 8'h3c);   // lost, still in reset
      bus_read(SAMPLES_ADDR, 1);
      bus_write(RESET_ADDR, 0, 8'h00);
      if (reset_o !== 1'b0) begin
         $display("error at %0t ns: reset_o %b after soft reset release", $time, reset_o);
         err_count++;
      end
      bus_read(ECHO_ADDR, 0);
      bus_read(ADVCLOCK_ADDR, 1);
      check_outputs();
      finish_test("soft reset", errs);

      errs = err_count;
      offs = 3 + $unsigned($random(seed)) % 8;
      hold = 2 + $unsigned($random(seed)) % 6;
      trigger_trial(offs, hold, 1'b0);
      m_trig_len = 32'(hold);
      for (int lane = 0; lane < 4; lane++) begin
         bus_read(TRIGGER_DUR_ADDR, lane);
      end
      trigger_trial(offs + 2, 0, 1'b1);
      bus_write(SETTINGS_ADDR, 0, 8'h00);
      check_outputs();
      finish_test("trigger timing", errs);

      $display("tests run %0d, tests failed %0d, read checks %0d, errors %0d",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== openadc_top.sv ====
`timescale 1ns/1ns

module openadc_top
   import openadc_hw_pkg::*;
   import openadc_reg_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 adc_sampleclk_i,
   input  logic                 reset_i,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_wdata_i,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   input  logic [7:0]           status_i,
   input  logic                 clkgen_locked_i,
   input  logic                 dcm_locked_i,
   input  logic                 trig_in_i,
   output logic                 reset_o,
   output logic [7:0]           reg_rdata_o,
   output logic [7:0]           gain_o,
   output logic                 hilow_o,
   output phase_t               phase_o,
   output logic                 phase_ld_o,
   output samples_t             maxsamples_o,
   output presamples_t          presamples_o,
   output logic [12:0]          downsample_o,
   output logic [2:0]           adc_clk_src_o,
   output logic                 dcm_reset_o,
   output logic                 capture_go_o
);

   logic      trigger_mode;
   logic      trigger_now;
   logic      cmd_arm;      // already in sample domain
   offset_t   trigger_offset;
   trig_len_t trigger_length;

   reg_openadc i_reg_openadc (
      .clk_usb, .adc_sampleclk_i, .reset_i,
      .reg_address_i, .reg_bytecnt_i, .reg_wdata_i, .reg_read_i, .reg_write_i,
      .status_i, .clkgen_locked_i, .dcm_locked_i,
      .trigger_length_i(trigger_length),
      .reset_o, .reg_rdata_o, .gain_o, .hilow_o,
      .trigger_mode_o(trigger_mode),
      .trigger_now_o(trigger_now),
      .cmd_arm_o(cmd_arm),
      .trigger_offset_o(trigger_offset),
      .phase_o, .phase_ld_o, .maxsamples_o, .presamples_o, .downsample_o,
      .adc_clk_src_o, .dcm_reset_o
   );

   trigger_unit i_trigger_unit (
      .adc_sampleclk_i,
      .reset_i(reset_o),            // includes soft reset
      .arm_i(cmd_arm),
      .trig_in_i,
      .trigger_mode_i(trigger_mode),
      .trigger_now_i(trigger_now),
      .trigger_offset_i(trigger_offset),
      .capture_go_o,
      .trigger_length_o(trigger_length)
   );

endmodule

// ==== reg_openadc.sv ====
`timescale 1ns/1ns

module reg_openadc
   import openadc_hw_pkg::*;
   import openadc_reg_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 adc_sampleclk_i,
   input  logic                 reset_i,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_wdata_i,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   input  logic [7:0]           status_i,
   input  logic                 clkgen_locked_i,
   input  logic                 dcm_locked_i,
   input  trig_len_t            trigger_length_i,
   output logic                 reset_o,
   output logic [7:0]           reg_rdata_o,
   output logic [7:0]           gain_o,
   output logic                 hilow_o,
   output logic                 trigger_mode_o,
   output logic                 trigger_now_o,
   output logic                 cmd_arm_o,
   output offset_t              trigger_offset_o,
   output phase_t               phase_o,
   output logic                 phase_ld_o,
   output samples_t             maxsamples_o,
   output presamples_t          presamples_o,
   output logic [12:0]          downsample_o,
   output logic [2:0]           adc_clk_src_o,
   output logic                 dcm_reset_o
);

   logic        reset;
   logic        soft_reset_q = 1'b0;   // power-up value only
   logic [7:0]  settings_q;
   logic [7:0]  echo_q;
   logic [31:0] advclock_q;
   logic [31:0] advclock_rd;
   logic [47:0] version_word;
   decimate_t   decimate_val;
   logic [7:0]  rd_samples;
   logic [7:0]  rd_presamples;
   logic [7:0]  rd_offset;
   logic [7:0]  rd_decimate;
   logic [7:0]  rd_phase;
   logic [7:0]  own_byte;
   logic [1:0]  arm_sync_q;
   logic        arm_r_q;
   logic        arm_r2_q;

   // byte of a word at the given lane, zero past bit 63
   function automatic logic [7:0] lane_byte(input logic [63:0] word,
                                            input logic [BYTECNT_W-1:0] lane);
      logic [7:0] b;
      b = 8'h00;
      for (int i = 0; i < 8; i++) begin
         if (lane == BYTECNT_W'(i)) begin
            b = word[i*8 +: 8];
         end
      end
      return b;
   endfunction

   assign reset   = reset_i | soft_reset_q;
   assign reset_o = reset;

   assign hilow_o        = settings_q[SET_HILOW];
   assign trigger_mode_o = settings_q[SET_TRIG_MODE];
   assign trigger_now_o  = settings_q[SET_TRIG_NOW];
   assign downsample_o   = decimate_val[12:0];
   assign adc_clk_src_o  = advclock_q[2:0];
   assign dcm_reset_o    = advclock_q[4];
   assign cmd_arm_o      = arm_r2_q;

   assign version_word = {32'h0, HW_TYPE, HW_VER, 4'h0, REGISTER_VERSION};
   assign advclock_rd  = {advclock_q[31:26], 1'b0, advclock_q[24:8], 1'b1,
                          dcm_locked_i, clkgen_locked_i, advclock_q[4:0]};

   // soft reset flag, still writable while reset is active
   always_ff @(posedge clk_usb) begin
      if (reg_write_i && reg_address_i == RESET_ADDR) begin
         soft_reset_q <= reg_wdata_i[0];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_o     <= 8'h00;
         settings_q <= 8'h00;
         echo_q     <= 8'h00;
         advclock_q <= ADVCLOCK_DEFAULT;
      end else if (reg_write_i) begin
         case (reg_address_i)
            GAIN_ADDR:     gain_o <= reg_wdata_i;
            SETTINGS_ADDR: settings_q <= reg_wdata_i;
            ECHO_ADDR:     echo_q <= reg_wdata_i;
            ADVCLOCK_ADDR: begin
               for (int i = 0; i < 4; i++) begin
                  if (reg_bytecnt_i == BYTECNT_W'(i)) begin
                     advclock_q[i*8 +: 8] <= reg_wdata_i;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         phase_ld_o <= 1'b0;
      end else begin
         phase_ld_o <= reg_write_i && (reg_address_i == PHASE_ADDR) &&
                       (reg_bytecnt_i == BYTECNT_W'(1));   // load on upper byte
      end
   end

   // arm into the sample domain: 2 sync flops then 2 pipeline flops
   always_ff @(posedge adc_sampleclk_i) begin
      if (reset) begin
         arm_sync_q <= 2'b00;
         arm_r_q    <= 1'b0;
         arm_r2_q   <= 1'b0;
      end else begin
         arm_sync_q <= {arm_sync_q[0], settings_q[SET_ARM]};
         arm_r_q    <= arm_sync_q[1];
         arm_r2_q   <= arm_r_q;
      end
   end

   always_comb begin
      case (reg_address_i)
         GAIN_ADDR:        own_byte = gain_o;
         SETTINGS_ADDR:    own_byte = settings_q;
         STATUS_ADDR:      own_byte = status_i;
         ECHO_ADDR:        own_byte = echo_q;
         VERSION_ADDR:     own_byte = lane_byte({16'h0, version_word}, reg_bytecnt_i);
         ADVCLOCK_ADDR:    own_byte = lane_byte({32'h0, advclock_rd}, reg_bytecnt_i);
         SYSTEMCLK_ADDR:   own_byte = lane_byte({32'h0, SYSTEM_CLK_HZ}, reg_bytecnt_i);
         TRIGGER_DUR_ADDR: own_byte = lane_byte({32'h0, trigger_length_i}, reg_bytecnt_i);
         default:          own_byte = 8'h00;
      endcase
   end

   // instances return zero unless addressed
   always_ff @(posedge clk_usb) begin
      if (reg_read_i) begin
         reg_rdata_o <= own_byte | rd_samples | rd_presamples | rd_offset |
                        rd_decimate | rd_phase;
      end else begin
         reg_rdata_o <= 8'h00;
      end
   end

   multibyte_reg #(.word_t(samples_t), .ADDR(SAMPLES_ADDR), .RESET_VAL(SAMPLES_DEFAULT))
   i_samples (
      .clk_usb, .reset_i(reset), .reg_write_i, .reg_read_i, .reg_address_i,
      .reg_bytecnt_i, .reg_wdata_i, .value_o(maxsamples_o), .rd_byte_o(rd_samples)
   );

   multibyte_reg #(.word_t(presamples_t), .ADDR(PRESAMPLES_ADDR), .RESET_VAL('0))
   i_presamples (
      .clk_usb, .reset_i(reset), .reg_write_i, .reg_read_i, .reg_address_i,
      .reg_bytecnt_i, .reg_wdata_i, .value_o(presamples_o), .rd_byte_o(rd_presamples)
   );

   multibyte_reg #(.word_t(offset_t), .ADDR(OFFSET_ADDR), .RESET_VAL('0))
   i_offset (
      .clk_usb, .reset_i(reset), .reg_write_i, .reg_read_i, .reg_address_i,
      .reg_bytecnt_i, .reg_wdata_i, .value_o(trigger_offset_o), .rd_byte_o(rd_offset)
   );

   multibyte_reg #(.word_t(decimate_t), .ADDR(DECIMATE_ADDR), .RESET_VAL('0))
   i_decimate (
      .clk_usb, .reset_i(reset), .reg_write_i, .reg_read_i, .reg_address_i,
      .reg_bytecnt_i, .reg_wdata_i, .value_o(decimate_val), .rd_byte_o(rd_decimate)
   );

   multibyte_reg #(.word_t(phase_t), .ADDR(PHASE_ADDR), .RESET_VAL('0))
   i_phase (
      .clk_usb, .reset_i(reset), .reg_write_i, .reg_read_i, .reg_address_i,
      .reg_bytecnt_i, .reg_wdata_i, .value_o(phase_o), .rd_byte_o(rd_phase)
   );

   ap_phase_ld_single: assert property (@(posedge clk_usb) disable iff (reset)
      phase_ld_o |=> !phase_ld_o);

endmodule

// ==== trigger_unit.sv ====
`timescale 1ns/1ns

module trigger_unit
   import openadc_reg_pkg::*;
(
   input  logic      adc_sampleclk_i,
   input  logic      reset_i,
   input  logic      arm_i,
   input  logic      trig_in_i,
   input  logic      trigger_mode_i,
   input  logic      trigger_now_i,
   input  offset_t   trigger_offset_i,
   output logic      capture_go_o,
   output trig_len_t trigger_length_o
);

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_ARMED,
      TRIG_COUNT
   } trig_state_t;

   trig_state_t state_q;
   logic        arm_q;
   logic        arm_rise;
   logic        trig_cond;
   offset_t     offset_cnt_q;
   logic        len_active_q;

   assign arm_rise  = arm_i & ~arm_q;
   assign trig_cond = (trig_in_i == trigger_mode_i) | trigger_now_i;

   always_ff @(posedge adc_sampleclk_i) begin
      if (reset_i) begin
         arm_q        <= 1'b0;
         state_q      <= TRIG_IDLE;
         capture_go_o <= 1'b0;
      end else begin
         arm_q        <= arm_i;
         capture_go_o <= 1'b0;
         case (state_q)
            TRIG_IDLE: begin
               if (arm_rise) begin
                  state_q <= TRIG_ARMED;
               end
            end
            TRIG_ARMED: begin
               if (trig_cond) begin
                  state_q <= TRIG_COUNT;   // this edge is the trigger edge
               end
            end
            TRIG_COUNT: begin
               if (offset_cnt_q == trigger_offset_i) begin
                  capture_go_o <= 1'b1;
                  state_q      <= TRIG_IDLE;   // rearm needs a new arm edge
               end
            end
            default: state_q <= TRIG_IDLE;
         endcase
      end
   end

   // holds k-1 on the k-th edge after the trigger
   always_ff @(posedge adc_sampleclk_i) begin
      if (state_q == TRIG_ARMED) begin
         offset_cnt_q <= '0;
      end else if (state_q == TRIG_COUNT) begin
         offset_cnt_q <= offset_cnt_q + 1'b1;
      end
   end

   // trigger edge counts as one, frozen once the condition drops
   always_ff @(posedge adc_sampleclk_i) begin
      if (reset_i || arm_rise) begin
         len_active_q     <= 1'b0;
         trigger_length_o <= '0;
      end else if (state_q == TRIG_ARMED && trig_cond) begin
         len_active_q     <= 1'b1;
         trigger_length_o <= trig_len_t'(1);
      end else if (len_active_q) begin
         if (trig_cond) begin
            trigger_length_o <= trigger_length_o + 1'b1;
         end else begin
            len_active_q <= 1'b0;
         end
      end
   end

   ap_capture_single: assert property (@(posedge adc_sampleclk_i) disable iff (reset_i)
      capture_go_o |=> !capture_go_o);

endmodule

// ==== multibyte_reg.sv ====
`timescale 1ns/1ns

module multibyte_reg
   import openadc_hw_pkg::*;
#(
   parameter type         word_t    = logic [31:0],
   parameter logic [7:0]  ADDR      = 8'h00,
   parameter word_t       RESET_VAL = '0
) (
   input  logic                 clk_usb,
   input  logic                 reset_i,
   input  logic                 reg_write_i,
   input  logic                 reg_read_i,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_wdata_i,
   output word_t                value_o,
   output logic [7:0]           rd_byte_o
);

   localparam int WORD_W    = $bits(word_t);
   localparam int NUM_LANES = (WORD_W + 7) / 8;   // last lane may be partial

   logic [NUM_LANES*8-1:0] wide_q;
   logic [NUM_LANES*8-1:0] wide_d;
   logic                   hit;
   logic                   lane_ok;

   assign hit     = (reg_address_i == ADDR);
   assign lane_ok = (reg_bytecnt_i < BYTECNT_W'(NUM_LANES));

   // zero-padded view so a partial top lane reads clean
   always_comb begin
      wide_q = '0;
      wide_q[WORD_W-1:0] = value_o;
      wide_d = wide_q;
      rd_byte_o = 8'h00;
      for (int i = 0; i < NUM_LANES; i++) begin
         if (reg_bytecnt_i == BYTECNT_W'(i)) begin
            wide_d[i*8 +: 8] = reg_wdata_i;
            if (reg_read_i && hit) begin
               rd_byte_o = wide_q[i*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         value_o <= RESET_VAL;
      end else if (reg_write_i && hit && lane_ok) begin
         value_o <= wide_d[WORD_W-1:0];   // padding bits dropped here
      end
   end

endmodule

// ==== openadc_reg_pkg.sv ====
package openadc_reg_pkg;

   // register map
   localparam logic [7:0] GAIN_ADDR        = 8'd0;
   localparam logic [7:0] SETTINGS_ADDR    = 8'd1;
   localparam logic [7:0] STATUS_ADDR      = 8'd2;
   localparam logic [7:0] ECHO_ADDR        = 8'd4;     // scratch byte for link tests
   localparam logic [7:0] VERSION_ADDR     = 8'd8;
   localparam logic [7:0] PHASE_ADDR       = 8'd9;
   localparam logic [7:0] DECIMATE_ADDR    = 8'd15;
   localparam logic [7:0] SAMPLES_ADDR     = 8'd16;
   localparam logic [7:0] PRESAMPLES_ADDR  = 8'd17;
   localparam logic [7:0] TRIGGER_DUR_ADDR = 8'd20;
   localparam logic [7:0] OFFSET_ADDR      = 8'd26;
   localparam logic [7:0] RESET_ADDR       = 8'd28;
   localparam logic [7:0] ADVCLOCK_ADDR    = 8'd44;
   localparam logic [7:0] SYSTEMCLK_ADDR   = 8'd48;

   // bit positions inside the settings byte
   localparam int SET_HILOW     = 1;    // high/low gain range
   localparam int SET_TRIG_MODE = 2;    // 1 = active high trigger
   localparam int SET_ARM       = 3;
   localparam int SET_TRIG_NOW  = 6;    // force trigger condition

   // register payloads
   typedef logic [31:0] samples_t;      // max samples per capture
   typedef logic [14:0] presamples_t;   // samples kept before trigger
   typedef logic [31:0] offset_t;       // trigger delay, sample clocks
   typedef logic [15:0] decimate_t;     // downsample factor
   typedef logic [15:0] phase_t;        // phase shift word
   typedef logic [31:0] trig_len_t;     // measured trigger length

   // reset defaults
   localparam logic [31:0] SAMPLES_DEFAULT  = 32'h0000_6000;
   localparam logic [31:0] ADVCLOCK_DEFAULT = 32'h0000_0102;   // adc clock from dcm

endpackage

// ==== openadc_hw_pkg.sv ====
package openadc_hw_pkg;

   // width of the byte-lane counter on the host bus
   localparam int BYTECNT_W = 7;

   // identity word fields, packed into the version read-back
   localparam logic [4:0] HW_TYPE          = 5'd8;     // board family code
   localparam logic [2:0] HW_VER           = 3'd0;
   localparam logic [3:0] REGISTER_VERSION = 4'd1;     // bump on any map change

   // nominal host clock, read back by software to scale timings
   localparam logic [31:0] SYSTEM_CLK_HZ = 32'd96_000_000;

endpackage
